/* exec_consts.svh */
// Width and size constants for the execute pipeline
// Word, register index, shift amount, byte lanes and link step

`ifndef EXEC_CONSTS_SVH
`define EXEC_CONSTS_SVH

// Data and address width, one word
`define EXEC_XLEN 32

// Register file index width
`define EXEC_REG_ADDR_W 5

// Shift amount taken from the low bits of op_b
`define EXEC_SHAMT_W 5

// Byte lanes per word, also the store enable width
`define EXEC_BYTE_LANES 4

// Link value is pc plus one instruction
`define EXEC_INSN_STEP 4

`endif

/* exec_pkg.sv */
// Shared types for the execute pipeline
// Operation enum, handshake state enums, request and result structs

package exec_pkg;

    `include "exec_consts.svh"

    ////////////////////////////////////////////////////////////
    // Enums
    ////////////////////////////////////////////////////////////

    typedef enum logic [4:0] {
        OP_NOP,
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_SLT,
        OP_SLTU,
        OP_LUI,
        OP_BEQ,
        OP_BNE,
        OP_BLT,
        OP_BLTU,
        OP_BGE,
        OP_BGEU,
        OP_JAL,
        OP_JALR,
        OP_LW,
        OP_SB,
        OP_SH,
        OP_SW
    } exec_op_e;

    // Receiver side of the input handshake
    typedef enum logic {
        RX_IDLE,
        RX_ACK
    } hs_rx_state_e;

    // Sender side of the output handshake
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_REQ,
        TX_WAIT_LOW
    } hs_tx_state_e;

    ////////////////////////////////////////////////////////////
    // Structs
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        exec_op_e                     op;
        logic [`EXEC_XLEN-1:0]        pc;
        logic [`EXEC_XLEN-1:0]        op_a;
        logic [`EXEC_XLEN-1:0]        op_b;
        logic [`EXEC_XLEN-1:0]        offset;
        logic [`EXEC_REG_ADDR_W-1:0]  rd;
    } exec_req_t;

    typedef struct packed {
        logic [`EXEC_XLEN-1:0]        addr;
        logic                         read_en;
        logic [`EXEC_BYTE_LANES-1:0]  write_en;
        logic [`EXEC_XLEN-1:0]        write_data;
    } mem_req_t;

    typedef struct packed {
        logic [`EXEC_XLEN-1:0]        result;
        logic [`EXEC_REG_ADDR_W-1:0]  rd;
        logic                         write_en;
        logic                         jump;
        logic [`EXEC_XLEN-1:0]        jump_target;
        mem_req_t                     mem;
    } exec_res_t;

endpackage

/* exec_accept.sv */
// Input stage of the execute pipeline
// Four-phase req/ack receiver and the first pipeline slot

module exec_accept (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                in_req_i,
    input  exec_pkg::exec_req_t in_data_i,
    input  logic                hold_i,
    output logic                in_ack_o,
    output logic                item_valid_o,
    output exec_pkg::exec_req_t item_o
);

    exec_pkg::hs_rx_state_e rx_state;
    logic                   slot_valid;
    exec_pkg::exec_req_t    slot_item;
    logic                   slot_leaving;
    logic                   capture;

    // Compute takes the item on this edge
    assign slot_leaving = slot_valid && !hold_i;

    // New request only when the slot is free after this edge
    assign capture = (rx_state == exec_pkg::RX_IDLE) && in_req_i
                     && (!slot_valid || slot_leaving);

    ////////////////////////////////////////////////////////////
    // Receiver FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rx_state <= exec_pkg::RX_IDLE;
            in_ack_o <= 1'b0;
        end else begin
            case (rx_state)
                exec_pkg::RX_IDLE: begin
                    if (capture) begin
                        rx_state <= exec_pkg::RX_ACK;
                        in_ack_o <= 1'b1;
                    end
                end
                exec_pkg::RX_ACK: begin
                    // Source has dropped req, finish the cycle
                    if (!in_req_i) begin
                        rx_state <= exec_pkg::RX_IDLE;
                        in_ack_o <= 1'b0;
                    end
                end
                default: begin
                    rx_state <= exec_pkg::RX_IDLE;
                    in_ack_o <= 1'b0;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Slot
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            slot_valid <= 1'b0;
        end else if (capture) begin
            slot_valid <= 1'b1;
        end else if (slot_leaving) begin
            slot_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            slot_item <= in_data_i;
        end
    end

    assign item_valid_o = slot_valid;
    assign item_o       = slot_item;

endmodule

/* exec_compute.sv */
// Middle stage of the execute pipeline
// ALU, branch compare, jump target, load/store formatting
// and the registered result slot

`include "exec_consts.svh"

module exec_compute (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                item_valid_i,
    input  exec_pkg::exec_req_t item_i,
    input  logic                hold_i,
    output logic                hold_o,
    output logic                res_valid_o,
    output exec_pkg::exec_res_t res_o
);

    logic [`EXEC_XLEN-1:0]       op_a;
    logic [`EXEC_XLEN-1:0]       op_b;
    logic [`EXEC_SHAMT_W-1:0]    shamt;
    logic [`EXEC_XLEN-1:0]       alu_result;
    logic [`EXEC_XLEN-1:0]       link;
    logic [`EXEC_XLEN-1:0]       a_plus_off;
    logic [`EXEC_XLEN-1:0]       pc_plus_off;
    logic                        equal;
    logic                        less_than;
    logic                        less_than_u;
    logic                        take_branch;
    logic [`EXEC_BYTE_LANES-1:0] lane_en;
    logic [`EXEC_XLEN-1:0]       store_data;
    exec_pkg::exec_res_t         res_next;
    exec_pkg::exec_res_t         res_q;
    logic                        res_valid;
    logic                        take;

    assign op_a  = item_i.op_a;
    assign op_b  = item_i.op_b;
    assign shamt = op_b[`EXEC_SHAMT_W-1:0];

    ////////////////////////////////////////////////////////////
    // ALU
    ////////////////////////////////////////////////////////////

    assign link        = item_i.pc + `EXEC_XLEN'(`EXEC_INSN_STEP);
    assign a_plus_off  = op_a + item_i.offset;
    assign pc_plus_off = item_i.pc + item_i.offset;

    assign equal       = (op_a == op_b);
    assign less_than   = $signed(op_a) < $signed(op_b);
    assign less_than_u = op_a < op_b;

    always_comb begin
        case (item_i.op)
            exec_pkg::OP_ADD:  alu_result = op_a + op_b;
            exec_pkg::OP_SUB:  alu_result = op_a - op_b;
            exec_pkg::OP_AND:  alu_result = op_a & op_b;
            exec_pkg::OP_OR:   alu_result = op_a | op_b;
            exec_pkg::OP_XOR:  alu_result = op_a ^ op_b;
            exec_pkg::OP_SLL:  alu_result = op_a << shamt;
            exec_pkg::OP_SRL:  alu_result = op_a >> shamt;
            exec_pkg::OP_SRA:  alu_result = $unsigned($signed(op_a) >>> shamt);
            exec_pkg::OP_SLT:  alu_result = {{(`EXEC_XLEN-1){1'b0}}, less_than};
            exec_pkg::OP_SLTU: alu_result = {{(`EXEC_XLEN-1){1'b0}}, less_than_u};
            exec_pkg::OP_LUI:  alu_result = op_b;
            exec_pkg::OP_JAL,
            exec_pkg::OP_JALR: alu_result = link;
            // Memory ops report the effective address
            exec_pkg::OP_LW,
            exec_pkg::OP_SB,
            exec_pkg::OP_SH,
            exec_pkg::OP_SW:   alu_result = a_plus_off;
            default:           alu_result = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Branch decision
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (item_i.op)
            exec_pkg::OP_BEQ:  take_branch = equal;
            exec_pkg::OP_BNE:  take_branch = !equal;
            exec_pkg::OP_BLT:  take_branch = less_than;
            exec_pkg::OP_BLTU: take_branch = less_than_u;
            exec_pkg::OP_BGE:  take_branch = !less_than;
            exec_pkg::OP_BGEU: take_branch = !less_than_u;
            exec_pkg::OP_JAL,
            exec_pkg::OP_JALR: take_branch = 1'b1;
            default:           take_branch = 1'b0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Store lanes and data
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (item_i.op)
            exec_pkg::OP_SB: begin
                lane_en    = `EXEC_BYTE_LANES'(1) << a_plus_off[1:0];
                store_data = {`EXEC_BYTE_LANES{op_b[7:0]}};
            end
            exec_pkg::OP_SH: begin
                // Upper or lower half picked by address bit 1
                lane_en    = a_plus_off[1] ? 4'b1100 : 4'b0011;
                store_data = {(`EXEC_BYTE_LANES/2){op_b[15:0]}};
            end
            exec_pkg::OP_SW: begin
                lane_en    = '1;
                store_data = op_b;
            end
            default: begin
                lane_en    = '0;
                store_data = '0;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Result assembly and slot
    ////////////////////////////////////////////////////////////

    always_comb begin
        res_next.result          = alu_result;
        res_next.rd              = item_i.rd;
        res_next.write_en        = (item_i.rd != '0) && !(item_i.op inside {
                                       exec_pkg::OP_NOP,
                                       exec_pkg::OP_BEQ, exec_pkg::OP_BNE,
                                       exec_pkg::OP_BLT, exec_pkg::OP_BLTU,
                                       exec_pkg::OP_BGE, exec_pkg::OP_BGEU,
                                       exec_pkg::OP_SB, exec_pkg::OP_SH,
                                       exec_pkg::OP_SW});
        res_next.jump            = take_branch;
        res_next.jump_target     = (item_i.op == exec_pkg::OP_JALR)
                                   ? {a_plus_off[`EXEC_XLEN-1:1], 1'b0}
                                   : pc_plus_off;
        res_next.mem.addr        = {a_plus_off[`EXEC_XLEN-1:2], 2'b00};
        res_next.mem.read_en     = (item_i.op == exec_pkg::OP_LW);
        res_next.mem.write_en    = lane_en;
        res_next.mem.write_data  = store_data;
    end

    // Stuck while holding a result that retire will not take
    assign hold_o = res_valid && hold_i;
    assign take   = item_valid_i && !hold_o;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            res_valid <= 1'b0;
        end else if (take) begin
            res_valid <= 1'b1;
        end else if (!hold_i) begin
            res_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            res_q <= res_next;
        end
    end

    assign res_valid_o = res_valid;
    assign res_o       = res_q;

endmodule

/* exec_retire.sv */
// Output stage of the execute pipeline
// Four-phase req/ack sender and the last pipeline slot

module exec_retire (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                res_valid_i,
    input  exec_pkg::exec_res_t res_i,
    input  logic                out_ack_i,
    output logic                hold_o,
    output logic                out_req_o,
    output exec_pkg::exec_res_t out_data_o
);

    exec_pkg::hs_tx_state_e tx_state;
    logic                   launch;

    // Start a transfer only from idle with the sink's ack low
    assign launch = (tx_state == exec_pkg::TX_IDLE) && res_valid_i && !out_ack_i;

    // Slot busy until the handshake has fully closed
    assign hold_o = (tx_state != exec_pkg::TX_IDLE) || out_ack_i;

    ////////////////////////////////////////////////////////////
    // Sender FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            tx_state  <= exec_pkg::TX_IDLE;
            out_req_o <= 1'b0;
        end else begin
            case (tx_state)
                exec_pkg::TX_IDLE: begin
                    if (launch) begin
                        tx_state  <= exec_pkg::TX_REQ;
                        out_req_o <= 1'b1;
                    end
                end
                exec_pkg::TX_REQ: begin
                    if (out_ack_i) begin
                        tx_state  <= exec_pkg::TX_WAIT_LOW;
                        out_req_o <= 1'b0;
                    end
                end
                exec_pkg::TX_WAIT_LOW: begin
                    // Data stays put until the sink releases ack
                    if (!out_ack_i) begin
                        tx_state <= exec_pkg::TX_IDLE;
                    end
                end
                default: begin
                    tx_state  <= exec_pkg::TX_IDLE;
                    out_req_o <= 1'b0;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Output data
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            out_data_o <= '0;
        end else if (launch) begin
            out_data_o <= res_i;
        end
    end

endmodule

/* exec_top.sv */
// Top level of the execute pipeline
// Chains accept, compute and retire stages

module exec_top (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                in_req_i,
    input  exec_pkg::exec_req_t in_data_i,
    input  logic                out_ack_i,
    output logic                in_ack_o,
    output logic                out_req_o,
    output exec_pkg::exec_res_t out_data_o
);

    // Accept to compute
    logic                item_valid;
    exec_pkg::exec_req_t item;
    logic                compute_hold;

    // Compute to retire
    logic                res_valid;
    exec_pkg::exec_res_t res;
    logic                retire_hold;

    exec_accept u_accept (
        .clk          (clk),
        .reset_n      (reset_n),
        .in_req_i     (in_req_i),
        .in_data_i    (in_data_i),
        .hold_i       (compute_hold),
        .in_ack_o     (in_ack_o),
        .item_valid_o (item_valid),
        .item_o       (item)
    );

    exec_compute u_compute (
        .clk          (clk),
        .reset_n      (reset_n),
        .item_valid_i (item_valid),
        .item_i       (item),
        .hold_i       (retire_hold),
        .hold_o       (compute_hold),
        .res_valid_o  (res_valid),
        .res_o        (res)
    );

    exec_retire u_retire (
        .clk          (clk),
        .reset_n      (reset_n),
        .res_valid_i  (res_valid),
        .res_i        (res),
        .out_ack_i    (out_ack_i),
        .hold_o       (retire_hold),
        .out_req_o    (out_req_o),
        .out_data_o   (out_data_o)
    );

endmodule

/* exec_sva.sv */
// Handshake and reset assertions for the execute pipeline
// Bound into exec_top

module exec_sva (
    input logic                clk,
    input logic                reset_n,
    input logic                in_req_i,
    input logic                in_ack_o,
    input logic                out_req_o,
    input logic                out_ack_i,
    input exec_pkg::exec_res_t out_data_o
);

    timeunit 1ns;
    timeprecision 1ps;

    // Both handshake outputs low while reset is held
    reset_outputs_low: assert property (
        @(posedge clk) !reset_n |-> !in_ack_o && !out_req_o
    ) else $error("in_ack_o or out_req_o high during reset");

    // Sink sees a frozen result for the whole request
    out_data_stable: assert property (
        @(posedge clk) disable iff (!reset_n)
        out_req_o |=> $stable(out_data_o)
    ) else $error("out_data_o changed while out_req_o was high");

    out_req_waits_ack_low: assert property (
        @(posedge clk) disable iff (!reset_n)
        !out_req_o && out_ack_i |=> !out_req_o
    ) else $error("out_req_o rose while out_ack_i was high");

    in_ack_held_with_req: assert property (
        @(posedge clk) disable iff (!reset_n)
        in_ack_o && in_req_i |=> in_ack_o
    ) else $error("in_ack_o fell while in_req_i was high");

    in_ack_needs_req: assert property (
        @(posedge clk) disable iff (!reset_n)
        !in_ack_o && !in_req_i |=> !in_ack_o
    ) else $error("in_ack_o rose with no request");

endmodule

bind exec_top exec_sva u_sva (
    .clk        (clk),
    .reset_n    (reset_n),
    .in_req_i   (in_req_i),
    .in_ack_o   (in_ack_o),
    .out_req_o  (out_req_o),
    .out_ack_i  (out_ack_i),
    .out_data_o (out_data_o)
);

/* tb_exec.sv */
// Testbench for the execute pipeline
// Four-phase driver, reference model, sink monitor and result checks

`include "exec_consts.svh"

module tb_exec;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYCLES = 1000;
    localparam int STALL_CYCLES   = 25;
    localparam int RANDOM_COUNT   = 300;

    logic                clk;
    logic                reset_n;
    logic                in_req;
    exec_pkg::exec_req_t in_data;
    logic                out_ack;
    logic                in_ack;
    logic                out_req;
    exec_pkg::exec_res_t out_data;

    // Expected results in issue order
    exec_pkg::exec_res_t exp_q [$];

    int   mismatch_count;
    int   timeout_count;
    int   other_count;
    int   sent_count;
    int   result_count;
    int   ack_delay_max;
    logic sink_hold;

    exec_top u_dut (
        .clk        (clk),
        .reset_n    (reset_n),
        .in_req_i   (in_req),
        .in_data_i  (in_data),
        .out_ack_i  (out_ack),
        .in_ack_o   (in_ack),
        .out_req_o  (out_req),
        .out_data_o (out_data)
    );

    always #10 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    // Drive and sample 1 ns after the rising edge
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("Mismatch %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic report_timeout(input string what);
        timeout_count++;
        $display("Timeout while waiting: %s at %0t", what, $time);
    endtask

    function automatic exec_pkg::exec_req_t make_req(
        input exec_pkg::exec_op_e op,
        input logic [31:0]        pc,
        input logic [31:0]        op_a,
        input logic [31:0]        op_b,
        input logic [31:0]        offset,
        input logic [4:0]         rd
    );
        exec_pkg::exec_req_t r;
        r.op     = op;
        r.pc     = pc;
        r.op_a   = op_a;
        r.op_b   = op_b;
        r.offset = offset;
        r.rd     = rd;
        return r;
    endfunction

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    function automatic exec_pkg::exec_res_t exec_model(input exec_pkg::exec_req_t r);
        exec_pkg::exec_res_t    e;
        logic [`EXEC_XLEN-1:0]  ea;
        logic [`EXEC_XLEN-1:0]  link;
        logic [4:0]             sh;
        logic                   no_write;
        e    = '0;
        ea   = r.op_a + r.offset;
        link = r.pc + 32'(`EXEC_INSN_STEP);
        sh   = r.op_b[4:0];
        e.rd          = r.rd;
        e.jump_target = r.pc + r.offset;
        e.mem.addr    = ea & 32'hffff_fffc;
        case (r.op)
            exec_pkg::OP_ADD:  e.result = r.op_a + r.op_b;
            exec_pkg::OP_SUB:  e.result = r.op_a - r.op_b;
            exec_pkg::OP_AND:  e.result = r.op_a & r.op_b;
            exec_pkg::OP_OR:   e.result = r.op_a | r.op_b;
            exec_pkg::OP_XOR:  e.result = r.op_a ^ r.op_b;
            exec_pkg::OP_SLL:  e.result = r.op_a << sh;
            exec_pkg::OP_SRL:  e.result = r.op_a >> sh;
            exec_pkg::OP_SRA:  e.result = $signed(r.op_a) >>> sh;
            exec_pkg::OP_SLT:  e.result = ($signed(r.op_a) < $signed(r.op_b)) ? 32'd1 : 32'd0;
            exec_pkg::OP_SLTU: e.result = (r.op_a < r.op_b) ? 32'd1 : 32'd0;
            exec_pkg::OP_LUI:  e.result = r.op_b;
            exec_pkg::OP_BEQ:  e.jump = (r.op_a == r.op_b);
            exec_pkg::OP_BNE:  e.jump = (r.op_a != r.op_b);
            exec_pkg::OP_BLT:  e.jump = ($signed(r.op_a) < $signed(r.op_b));
            exec_pkg::OP_BLTU: e.jump = (r.op_a < r.op_b);
            exec_pkg::OP_BGE:  e.jump = ($signed(r.op_a) >= $signed(r.op_b));
            exec_pkg::OP_BGEU: e.jump = (r.op_a >= r.op_b);
            exec_pkg::OP_JAL: begin
                e.result = link;
                e.jump   = 1'b1;
            end
            exec_pkg::OP_JALR: begin
                e.result      = link;
                e.jump        = 1'b1;
                e.jump_target = ea & 32'hffff_fffe;
            end
            exec_pkg::OP_LW: begin
                e.result      = ea;
                e.mem.read_en = 1'b1;
            end
            exec_pkg::OP_SB: begin
                e.result         = ea;
                e.mem.write_en   = 4'b0001 << ea[1:0];
                e.mem.write_data = {4{r.op_b[7:0]}};
            end
            exec_pkg::OP_SH: begin
                e.result         = ea;
                e.mem.write_en   = 4'b0011 << {ea[1], 1'b0};
                e.mem.write_data = {2{r.op_b[15:0]}};
            end
            exec_pkg::OP_SW: begin
                e.result         = ea;
                e.mem.write_en   = 4'b1111;
                e.mem.write_data = r.op_b;
            end
            default: e.result = '0;
        endcase
        // No register write for NOP, branches and stores
        no_write = (r.op == exec_pkg::OP_NOP)
                   || (r.op >= exec_pkg::OP_BEQ && r.op <= exec_pkg::OP_BGEU)
                   || (r.op >= exec_pkg::OP_SB && r.op <= exec_pkg::OP_SW);
        e.write_en = (r.rd != 5'd0) && !no_write;
        return e;
    endfunction

    task automatic compare_result(input exec_pkg::exec_res_t got,
                                  input exec_pkg::exec_res_t exp);
        check_value("result", got.result, exp.result);
        check_value("rd", 32'(got.rd), 32'(exp.rd));
        check_value("write_en", 32'(got.write_en), 32'(exp.write_en));
        check_value("jump", 32'(got.jump), 32'(exp.jump));
        check_value("jump_target", got.jump_target, exp.jump_target);
        check_value("mem.addr", got.mem.addr, exp.mem.addr);
        check_value("mem.read_en", 32'(got.mem.read_en), 32'(exp.mem.read_en));
        check_value("mem.write_en", 32'(got.mem.write_en), 32'(exp.mem.write_en));
        check_value("mem.write_data", got.mem.write_data, exp.mem.write_data);
    endtask

    ////////////////////////////////////////////////////////////
    // Driver
    ////////////////////////////////////////////////////////////

    task automatic start_req(input exec_pkg::exec_req_t req);
        exp_q.push_back(exec_model(req));
        sent_count++;
        in_data = req;
        in_req  = 1'b1;
    endtask

    task automatic complete_req();
        int cycles;
        int hold;
        cycles = 0;
        while (!in_ack && cycles < TIMEOUT_CYCLES) begin
            tick();
            cycles++;
        end
        if (!in_ack) begin
            report_timeout("in_ack_o to rise");
        end
        // Source may keep req up a few cycles past the ack
        hold = $urandom % 3;
        repeat (hold) tick();
        in_req = 1'b0;
        cycles = 0;
        while (in_ack && cycles < TIMEOUT_CYCLES) begin
            tick();
            cycles++;
        end
        if (in_ack) begin
            report_timeout("in_ack_o to fall");
        end
    endtask

    task automatic send(input exec_pkg::exec_req_t req);
        start_req(req);
        complete_req();
    endtask

    task automatic drain();
        int cycles;
        cycles = 0;
        while ((exp_q.size() != 0 || out_req) && cycles < TIMEOUT_CYCLES) begin
            tick();
            cycles++;
        end
        if (exp_q.size() != 0) begin
            report_timeout("outstanding results to arrive");
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequences
    ////////////////////////////////////////////////////////////

    task automatic run_alu_tests();
        send(make_req(exec_pkg::OP_ADD, 32'h0, 32'd5, 32'd7, 32'h0, 5'd1));
        // Wraps below zero
        send(make_req(exec_pkg::OP_SUB, 32'h0, 32'd0, 32'd1, 32'h0, 5'd2));
        send(make_req(exec_pkg::OP_AND, 32'h0, 32'hf0f0_f0f0, 32'hff00_ff00, 32'h0, 5'd3));
        send(make_req(exec_pkg::OP_OR, 32'h0, 32'hf0f0_f0f0, 32'h0f00_000f, 32'h0, 5'd4));
        send(make_req(exec_pkg::OP_XOR, 32'h0, 32'hdead_beef, 32'hffff_0000, 32'h0, 5'd5));
        // Shift amounts above 31 use the low five bits
        send(make_req(exec_pkg::OP_SLL, 32'h0, 32'h0000_0001, 32'd33, 32'h0, 5'd6));
        send(make_req(exec_pkg::OP_SRL, 32'h0, 32'h8000_0000, 32'd36, 32'h0, 5'd7));
        send(make_req(exec_pkg::OP_SRA, 32'h0, 32'h8000_0010, 32'd4, 32'h0, 5'd8));
        send(make_req(exec_pkg::OP_SRA, 32'h0, 32'hf000_0000, 32'd35, 32'h0, 5'd8));
        // Mixed signs split SLT and SLTU
        send(make_req(exec_pkg::OP_SLT, 32'h0, 32'hffff_ffff, 32'd1, 32'h0, 5'd9));
        send(make_req(exec_pkg::OP_SLTU, 32'h0, 32'hffff_ffff, 32'd1, 32'h0, 5'd10));
        send(make_req(exec_pkg::OP_SLT, 32'h0, 32'd1, 32'hffff_ffff, 32'h0, 5'd9));
        send(make_req(exec_pkg::OP_SLTU, 32'h0, 32'd1, 32'hffff_ffff, 32'h0, 5'd10));
        send(make_req(exec_pkg::OP_LUI, 32'h0, 32'h0, 32'h1234_5000, 32'h0, 5'd11));
        send(make_req(exec_pkg::OP_ADD, 32'h0, 32'd3, 32'd4, 32'h0, 5'd0));
        send(make_req(exec_pkg::OP_NOP, 32'h0, 32'd3, 32'd4, 32'h0, 5'd12));
    endtask

    task automatic run_branch_tests();
        logic [31:0]        a_vals [5];
        logic [31:0]        b_vals [5];
        exec_pkg::exec_op_e op;
        int                 i;
        int                 p;
        // Equal, less, greater and both mixed-sign orders
        a_vals = '{32'd5, 32'd3, 32'd9, 32'hffff_fff0, 32'h0000_0010};
        b_vals = '{32'd5, 32'd9, 32'd3, 32'h0000_0010, 32'hffff_fff0};
        op = exec_pkg::OP_BEQ;
        for (i = 0; i < 6; i++) begin
            for (p = 0; p < 5; p++) begin
                send(make_req(op, 32'h0000_1000, a_vals[p], b_vals[p], 32'hffff_ff80, 5'd4));
            end
            op = op.next();
        end
        send(make_req(exec_pkg::OP_JAL, 32'h0000_0200, 32'h0, 32'h0, 32'h0000_07fc, 5'd1));
        // Target bit 0 cleared
        send(make_req(exec_pkg::OP_JALR, 32'h0000_0400, 32'h0000_3001, 32'h0, 32'h10, 5'd5));
        send(make_req(exec_pkg::OP_JALR, 32'h0000_0400, 32'h0000_3000, 32'h0, 32'h3, 5'd0));
    endtask

    task automatic run_memory_tests();
        exec_pkg::exec_op_e op;
        int                 i;
        int                 off;
        op = exec_pkg::OP_LW;
        for (i = 0; i < 4; i++) begin
            for (off = 0; off < 4; off++) begin
                send(make_req(op, 32'h0, 32'h0000_2000, 32'ha1b2_c3d4, 32'(off), 5'd6));
            end
            op = op.next();
        end
    endtask

    task automatic run_stall_test();
        int cycles;
        int i;
        sink_hold = 1'b1;
        // Three items fill accept, compute and retire
        for (i = 0; i < 3; i++) begin
            send(make_req(exec_pkg::OP_ADD, 32'h0, 32'(i), 32'h100, 32'h0, 5'(i + 1)));
        end
        start_req(make_req(exec_pkg::OP_XOR, 32'h0, 32'h5555_5555, 32'hffff_ffff, 32'h0, 5'd9));
        for (cycles = 0; cycles < STALL_CYCLES; cycles++) begin
            tick();
            if (in_ack) begin
                other_count++;
                $display("in_ack_o rose while the pipeline was full at %0t", $time);
            end
        end
        sink_hold = 1'b0;
        complete_req();
    endtask

    task automatic run_random_tests();
        exec_pkg::exec_req_t req;
        logic [31:0]         op_idx;
        logic [31:0]         bits;
        int                  n;
        for (n = 0; n < RANDOM_COUNT; n++) begin
            op_idx     = $urandom % 24;
            bits       = $urandom;
            req.op     = exec_pkg::exec_op_e'(op_idx[4:0]);
            req.pc     = $urandom;
            req.op_a   = $urandom;
            req.op_b   = $urandom;
            req.offset = $urandom;
            req.rd     = bits[4:0];
            // Ties now and then for BEQ and BGE
            if (bits[8:7] == 2'b00) begin
                req.op_b = req.op_a;
            end
            repeat (bits[11:10]) tick();
            send(req);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Sink monitor
    ////////////////////////////////////////////////////////////

    initial begin : monitor
        int                  delay;
        int                  cycles;
        exec_pkg::exec_res_t expected;
        forever begin
            tick();
            if (out_req) begin
                result_count++;
                if (exp_q.size() == 0) begin
                    other_count++;
                    $display("A result arrived with no request outstanding at %0t", $time);
                end else begin
                    expected = exp_q.pop_front();
                    compare_result(out_data, expected);
                end
                delay  = $urandom % (ack_delay_max + 1);
                cycles = 0;
                while ((cycles < delay || sink_hold) && cycles < TIMEOUT_CYCLES) begin
                    tick();
                    cycles++;
                end
                if (cycles >= TIMEOUT_CYCLES) begin
                    report_timeout("the sink stall to end");
                end
                out_ack = 1'b1;
                cycles  = 0;
                while (out_req && cycles < TIMEOUT_CYCLES) begin
                    tick();
                    cycles++;
                end
                if (out_req) begin
                    report_timeout("out_req_o to fall");
                end
                // Sink may keep ack up a few cycles after req drops
                delay = $urandom % (ack_delay_max + 1);
                repeat (delay) tick();
                out_ack = 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin : main
        clk            = 1'b0;
        reset_n        = 1'b0;
        in_req         = 1'b0;
        in_data        = '0;
        out_ack        = 1'b0;
        sink_hold      = 1'b0;
        ack_delay_max  = 0;
        mismatch_count = 0;
        timeout_count  = 0;
        other_count    = 0;
        sent_count     = 0;
        result_count   = 0;
        void'($urandom(68));
        repeat (3) @(posedge clk);
        #1;
        reset_n = 1'b1;
        tick();
        run_alu_tests();
        ack_delay_max = 3;
        run_branch_tests();
        run_memory_tests();
        drain();
        run_stall_test();
        drain();
        ack_delay_max = 6;
        run_random_tests();
        drain();
        if (result_count != sent_count) begin
            other_count++;
            $display("Sent %0d requests but received %0d results", sent_count, result_count);
        end
        $display("Summary: %0d mismatches, %0d timeouts, %0d other errors",
                 mismatch_count, timeout_count, other_count);
        if (mismatch_count + timeout_count + other_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* exec.f */
+incdir+.
exec_pkg.sv
exec_accept.sv
exec_compute.sv
exec_retire.sv
exec_top.sv
exec_sva.sv
tb_exec.sv

/* Makefile */
TOOL     := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/1ps
TOP      := tb_exec
FILELIST := exec.f
OBJ_DIR  := obj_dir
LOG      := sim.log
FAIL_MSG := Testbench failed
PASS_MSG := Testbench passed

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation did not complete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
